/* hw/cmpr_pkg.sv */
package cmpr_pkg;

    // page and line geometry
    localparam int WAY_W          = 36;       // way number is addr bits 47:12
    localparam int ADDR_W         = 48;
    localparam int PAGE_SHIFT     = 12;
    localparam int PAGE_BYTES     = 4096;
    localparam int LINE_W         = 512;
    localparam int LINE_BYTES     = 64;
    localparam int LINES_PER_PAGE = 64;
    localparam int LINE_IDX_W     = $clog2(LINES_PER_PAGE);
    localparam int WORD_W         = 64;       // zero elimination granule
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;

    // zspage layout, metadata sits ahead of slot 0
    localparam int ZS_OFFSET   = 64;
    localparam int NUM_CLASSES = 3;
    localparam int CLASS_W     = $clog2(NUM_CLASSES + 1);  // top code means uncompressed
    localparam int CLASS_SLOT_BYTES [NUM_CLASSES] = '{512, 1024, 2048};
    localparam int CLASS_SLOTS [NUM_CLASSES] = '{
        (PAGE_BYTES - ZS_OFFSET) / CLASS_SLOT_BYTES[0],   // 7
        (PAGE_BYTES - ZS_OFFSET) / CLASS_SLOT_BYTES[1],   // 3
        (PAGE_BYTES - ZS_OFFSET) / CLASS_SLOT_BYTES[2]    // 1
    };

    // compressed size, worst case 64 * 65 bytes
    localparam int SIZE_W     = 13;
    localparam int CMPR_LIMIT = 2048;

    // credit pools
    localparam int MEM_CREDITS = 8;
    localparam int MEM_CRD_W   = $clog2(MEM_CREDITS + 1);
    localparam int WR_CREDITS  = 2;
    localparam int WR_CRD_W    = $clog2(WR_CREDITS + 1);

    // completion status
    localparam int STS_W = 2;
    localparam logic [STS_W-1:0] STS_UNCOMP   = 2'd0;  // page kept as is
    localparam logic [STS_W-1:0] STS_NEW_ZSPG = 2'd1;  // victim way became a zspage
    localparam logic [STS_W-1:0] STS_PACKED   = 2'd2;  // packed, victim way freed

endpackage

/* hw/page_reader.sv */
module page_reader
    import cmpr_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              rd_start,
    input  logic [WAY_W-1:0]  rd_way,
    output logic              mem_req_valid,
    output logic [ADDR_W-1:0] mem_req_addr,
    input  logic              mem_credit_ret,
    input  logic              mem_rsp_valid,
    input  logic [LINE_W-1:0] mem_rsp_data,
    output logic              line_valid,
    output logic [LINE_W-1:0] line_data,
    output logic              rd_done
);

    logic [WAY_W-1:0]      way_q;
    logic [LINE_IDX_W:0]   req_idx_q;   // msb set once all lines are issued
    logic [LINE_IDX_W-1:0] rsp_idx_q;
    logic [MEM_CRD_W-1:0]  credits_q;

    // one request per cycle while lines remain and a credit is held
    assign mem_req_valid = !req_idx_q[LINE_IDX_W] && (credits_q != '0);
    assign mem_req_addr  = (ADDR_W'(way_q) << PAGE_SHIFT)
                         + ADDR_W'(req_idx_q[LINE_IDX_W-1:0]) * LINE_BYTES;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_idx_q  <= (LINE_IDX_W + 1)'(LINES_PER_PAGE);  // idle, nothing to issue
            rsp_idx_q  <= '0;
            credits_q  <= MEM_CRD_W'(MEM_CREDITS);
            line_valid <= 1'b0;
            rd_done    <= 1'b0;
        end else begin
            if (rd_start) begin
                req_idx_q <= '0;
                rsp_idx_q <= '0;
            end else begin
                if (mem_req_valid) begin
                    req_idx_q <= req_idx_q + 1'b1;
                end
                if (mem_rsp_valid) begin
                    rsp_idx_q <= rsp_idx_q + 1'b1;  // responses come back in order
                end
            end
            credits_q  <= credits_q - MEM_CRD_W'(mem_req_valid)
                        + MEM_CRD_W'(mem_credit_ret);
            line_valid <= mem_rsp_valid;
            rd_done    <= mem_rsp_valid && (rsp_idx_q == '1);  // tags the last line
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_start) begin
            way_q <= rd_way;
        end
        if (mem_rsp_valid) begin
            line_data <= mem_rsp_data;
        end
    end

    // returns must pair with earlier requests
    a_mem_credits: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credits_q <= MEM_CRD_W'(MEM_CREDITS));

endmodule

/* hw/line_compressor.sv */
module line_compressor
    import cmpr_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               line_valid,
    input  logic [LINE_W-1:0]  line_data,
    input  logic               rd_done,
    output logic               cmp_valid,
    output logic [SIZE_W-1:0]  cmp_size,
    output logic [CLASS_W-1:0] cmp_class
);

    logic [SIZE_W-1:0]  sum_q;
    logic [SIZE_W-1:0]  line_cost;
    logic [SIZE_W-1:0]  total;
    logic [CLASS_W-1:0] cls;

    // mask byte plus the surviving non-zero words
    always_comb begin
        line_cost = SIZE_W'(1);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (line_data[w*WORD_W +: WORD_W] != '0) begin
                line_cost = line_cost + SIZE_W'(WORD_W / 8);
            end
        end
    end

    assign total = sum_q + line_cost;

    // smallest slot that holds the page, scanned from the largest down
    always_comb begin
        cls = CLASS_W'(NUM_CLASSES);
        for (int c = NUM_CLASSES - 1; c >= 0; c--) begin
            if (total <= SIZE_W'(CLASS_SLOT_BYTES[c])) begin
                cls = CLASS_W'(c);
            end
        end
        if (total > SIZE_W'(CMPR_LIMIT)) begin
            cls = CLASS_W'(NUM_CLASSES);   // not worth storing compressed
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sum_q     <= '0;
            cmp_valid <= 1'b0;
        end else begin
            cmp_valid <= line_valid && rd_done;
            if (line_valid) begin
                sum_q <= rd_done ? '0 : total;  // restart for the next page
            end
        end
    end

    // result holds until the next page ends
    always_ff @(posedge clk_i) begin
        if (line_valid && rd_done) begin
            cmp_size  <= total;
            cmp_class <= cls;
        end
    end

endmodule

/* hw/size_class_bin.sv */
module size_class_bin
    import cmpr_pkg::*;
#(
    parameter int CLASS_IDX = 0
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              place_req,
    input  logic [WAY_W-1:0]  place_way,
    output logic [ADDR_W-1:0] slot_addr,
    output logic              new_zspg
);

    localparam int SLOTS      = CLASS_SLOTS[CLASS_IDX];
    localparam int SLOT_BYTES = CLASS_SLOT_BYTES[CLASS_IDX];
    localparam int IDX_W      = $clog2(SLOTS + 1);

    logic             open_q;      // under-construction zspage present
    logic [WAY_W-1:0] zs_way_q;
    logic [IDX_W-1:0] slot_idx_q;  // next free slot
    logic [WAY_W-1:0] base_way;
    logic [IDX_W-1:0] slot_idx;

    // with nothing open the victim itself hosts slot 0
    assign new_zspg  = !open_q;
    assign base_way  = open_q ? zs_way_q : place_way;
    assign slot_idx  = open_q ? slot_idx_q : '0;
    assign slot_addr = (ADDR_W'(base_way) << PAGE_SHIFT) + ADDR_W'(ZS_OFFSET)
                     + ADDR_W'(slot_idx) * SLOT_BYTES;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            open_q     <= 1'b0;
            slot_idx_q <= '0;
        end else if (place_req) begin
            if (slot_idx == IDX_W'(SLOTS - 1)) begin
                open_q     <= 1'b0;   // last slot used, zspage full
                slot_idx_q <= '0;
            end else begin
                open_q     <= 1'b1;
                slot_idx_q <= slot_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (place_req) begin
            zs_way_q <= base_way;
        end
    end

    a_slot_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        open_q |-> (slot_idx_q < IDX_W'(SLOTS)));

endmodule

/* hw/zspg_writer.sv */
module zspg_writer
    import cmpr_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               wr_go,
    input  logic [CLASS_W-1:0] sel_class,
    input  logic [ADDR_W-1:0]  slot_addr_all [NUM_CLASSES],
    input  logic [SIZE_W-1:0]  cmp_size,
    input  logic [WAY_W-1:0]   place_way,
    output logic               wr_valid,
    output logic [ADDR_W-1:0]  wr_addr,
    output logic [SIZE_W-1:0]  wr_size,
    output logic [CLASS_W-1:0] wr_class,
    output logic [WAY_W-1:0]   wr_way,
    input  logic               wr_credit_ret,
    output logic               wr_accepted
);

    logic                pend_q;     // packet held, waiting for a credit
    logic [WR_CRD_W-1:0] credits_q;

    assign wr_valid    = pend_q && (credits_q != '0);
    assign wr_accepted = wr_valid;   // no ready on this path, a credit is enough

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q    <= 1'b0;
            credits_q <= WR_CRD_W'(WR_CREDITS);
        end else begin
            if (wr_go) begin
                pend_q <= 1'b1;
            end else if (wr_valid) begin
                pend_q <= 1'b0;
            end
            credits_q <= credits_q - WR_CRD_W'(wr_valid) + WR_CRD_W'(wr_credit_ret);
        end
    end

    // capture the selected bin's answer before it advances
    always_ff @(posedge clk_i) begin
        if (wr_go) begin
            wr_addr  <= slot_addr_all[sel_class];
            wr_size  <= cmp_size;
            wr_class <= sel_class;
            wr_way   <= place_way;
        end
    end

    a_wr_credits: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credits_q <= WR_CRD_W'(WR_CREDITS));

endmodule

/* hw/cmpresn_mngr.sv */
module cmpresn_mngr
    import cmpr_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   cmpresn_trigger,
    input  logic [WAY_W-1:0]       victim_way,
    output logic                   busy,
    output logic                   rd_start,
    output logic [WAY_W-1:0]       rd_way,
    input  logic                   mem_rsp_valid,
    input  logic                   mem_rsp_err,
    input  logic                   cmp_valid,
    input  logic [SIZE_W-1:0]      cmp_size,
    input  logic [CLASS_W-1:0]     cmp_class,
    output logic [NUM_CLASSES-1:0] place_req,
    output logic [WAY_W-1:0]       place_way,
    output logic [CLASS_W-1:0]     sel_class,
    input  logic [ADDR_W-1:0]      slot_addr,
    input  logic                   new_zspg,
    output logic                   wr_go,
    input  logic                   wr_accepted,
    output logic                   cmpresn_done,
    output logic [STS_W-1:0]       done_status,
    output logic [ADDR_W-1:0]      cpage_addr,
    output logic                   free_valid,
    output logic [WAY_W-1:0]       free_way,
    output logic                   bus_error
);

    typedef enum logic [2:0] {
        IDLE, READ, COMPRESS, PLACE, WRITE, DONE, BUS_ERROR
    } state_t;

    state_t                state_q, state_d;
    logic [LINE_IDX_W-1:0] rsp_cnt_q;   // wraps to 0 after the last line
    logic [WAY_W-1:0]      victim_q;
    logic [CLASS_W-1:0]    cls_q;
    logic [STS_W-1:0]      status_q;
    logic [ADDR_W-1:0]     cpage_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmpresn_trigger) begin
                    state_d = READ;
                end
            end
            READ: begin
                if (mem_rsp_valid && mem_rsp_err) begin
                    state_d = BUS_ERROR;
                end else if (mem_rsp_valid && rsp_cnt_q == '1) begin
                    state_d = COMPRESS;
                end
            end
            COMPRESS: begin
                if (cmp_valid) begin
                    state_d = (cmp_size > SIZE_W'(CMPR_LIMIT)) ? DONE : PLACE;
                end
            end
            PLACE:     state_d = WRITE;   // bin answers and advances this cycle
            WRITE: begin
                if (wr_accepted) begin
                    state_d = DONE;
                end
            end
            DONE:      state_d = IDLE;
            BUS_ERROR: state_d = BUS_ERROR;  // only reset leaves
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            rsp_cnt_q <= '0;
            victim_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && cmpresn_trigger) begin
                victim_q  <= victim_way;
                rsp_cnt_q <= '0;
            end else if (state_q == READ && mem_rsp_valid) begin
                rsp_cnt_q <= rsp_cnt_q + 1'b1;
            end
        end
    end

    // completion payload held for the DONE cycle
    always_ff @(posedge clk_i) begin
        if (state_q == COMPRESS && cmp_valid) begin
            cls_q    <= cmp_class;
            status_q <= STS_UNCOMP;
            cpage_q  <= ADDR_W'(victim_q) << PAGE_SHIFT;  // page stays where it is
        end
        if (state_q == PLACE) begin
            status_q <= new_zspg ? STS_NEW_ZSPG : STS_PACKED;
            cpage_q  <= slot_addr;
        end
    end

    assign busy         = (state_q != IDLE);
    assign rd_start     = (state_q == IDLE) && cmpresn_trigger;
    assign rd_way       = victim_way;
    assign place_way    = victim_q;
    assign sel_class    = cls_q;
    assign place_req    = (state_q == PLACE) ? (NUM_CLASSES'(1) << cls_q) : '0;
    assign wr_go        = (state_q == PLACE);
    assign cmpresn_done = (state_q == DONE);
    assign done_status  = status_q;
    assign cpage_addr   = cpage_q;
    assign free_valid   = cmpresn_done && (status_q == STS_PACKED);
    assign free_way     = victim_q;
    assign bus_error    = (state_q == BUS_ERROR);

    // a new page starts only once every response of the last one is back
    a_trigger_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_start |-> !mem_rsp_valid);

endmodule

/* hw/cmpresn_top.sv */
module cmpresn_top
    import cmpr_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               cmpresn_trigger,
    input  logic [WAY_W-1:0]   victim_way,
    output logic               busy,
    output logic               mem_req_valid,
    output logic [ADDR_W-1:0]  mem_req_addr,
    input  logic               mem_credit_ret,
    input  logic               mem_rsp_valid,
    input  logic [LINE_W-1:0]  mem_rsp_data,
    input  logic               mem_rsp_err,
    output logic               wr_valid,
    output logic [ADDR_W-1:0]  wr_addr,
    output logic [SIZE_W-1:0]  wr_size,
    output logic [CLASS_W-1:0] wr_class,
    output logic [WAY_W-1:0]   wr_way,
    input  logic               wr_credit_ret,
    output logic               cmpresn_done,
    output logic [STS_W-1:0]   done_status,
    output logic [ADDR_W-1:0]  cpage_addr,
    output logic               free_valid,
    output logic [WAY_W-1:0]   free_way,
    output logic               bus_error
);

    logic                   rd_start, rd_done, line_valid, cmp_valid, wr_go, wr_accepted;
    logic [WAY_W-1:0]       rd_way, place_way;
    logic [LINE_W-1:0]      line_data;
    logic [SIZE_W-1:0]      cmp_size;
    logic [CLASS_W-1:0]     cmp_class, sel_class;
    logic [NUM_CLASSES-1:0] place_req, new_zspg_all;
    logic [ADDR_W-1:0]      slot_addr_all [NUM_CLASSES];

    cmpresn_mngr u_mngr (
        .clk_i, .rst_ni, .cmpresn_trigger, .victim_way, .busy, .rd_start, .rd_way,
        .mem_rsp_valid, .mem_rsp_err, .cmp_valid, .cmp_size, .cmp_class,
        .place_req, .place_way, .sel_class,
        .slot_addr (slot_addr_all[sel_class]),   // answer of the bin being placed
        .new_zspg  (new_zspg_all[sel_class]),
        .wr_go, .wr_accepted, .cmpresn_done, .done_status, .cpage_addr,
        .free_valid, .free_way, .bus_error
    );

    page_reader u_reader (
        .clk_i, .rst_ni, .rd_start, .rd_way, .mem_req_valid, .mem_req_addr,
        .mem_credit_ret, .mem_rsp_valid, .mem_rsp_data, .line_valid, .line_data, .rd_done
    );

    line_compressor u_compressor (
        .clk_i, .rst_ni, .line_valid, .line_data, .rd_done, .cmp_valid, .cmp_size, .cmp_class
    );

    // one under-construction zspage per class
    for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_bin
        size_class_bin #(.CLASS_IDX(c)) u_bin (
            .clk_i, .rst_ni, .place_req (place_req[c]), .place_way,
            .slot_addr (slot_addr_all[c]), .new_zspg (new_zspg_all[c])
        );
    end

    zspg_writer u_writer (
        .clk_i, .rst_ni, .wr_go, .sel_class, .slot_addr_all, .cmp_size, .place_way,
        .wr_valid, .wr_addr, .wr_size, .wr_class, .wr_way, .wr_credit_ret, .wr_accepted
    );

endmodule

/* verif/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk_i,
    output logic rst_ni
);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;  // period 10
    end

    initial begin
        rst_ni = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;  // release away from the active edge
    end

endmodule

/* verif/cmpresn_tb.sv */
module cmpresn_tb
    import cmpr_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 40 * 600;  // triggers times worst page time
    localparam int ERR_LINE       = 20;        // line answered with the error bit
    localparam int THRESH [8]     = '{0, 1, 2, 5, 6, 10, 12, 22};  // nonzero odds in 32nds

    logic               clk_i, rst_ni, cmpresn_trigger, busy, bus_error;
    logic [WAY_W-1:0]   victim_way, wr_way, free_way;
    logic               mem_req_valid, mem_credit_ret, mem_rsp_valid, mem_rsp_err;
    logic [ADDR_W-1:0]  mem_req_addr, wr_addr, cpage_addr;
    logic [LINE_W-1:0]  mem_rsp_data;
    logic               wr_valid, wr_credit_ret, cmpresn_done, free_valid;
    logic [SIZE_W-1:0]  wr_size;
    logic [CLASS_W-1:0] wr_class;
    logic [STS_W-1:0]   done_status;

    logic [31:0]       lfsr_q;
    logic [WAY_W-1:0]  cur_way;     // page being served by the responder
    int                zthresh;
    logic              err_page, hold_mem, hold_wr;
    int                cycles, pages, total_req, total_rsp, mem_seen_ret, mem_ret_drv;
    int                wr_sent, wr_seen_ret, wr_ret_drv, done_count, cum_cost;
    int                cost_base, wr_base, done_base;
    logic [ADDR_W-1:0] got_wr_addr, got_cpage;
    logic [SIZE_W-1:0] got_wr_size;
    logic [CLASS_W-1:0] got_wr_class;
    logic [WAY_W-1:0]  got_wr_way, got_free_way;
    logic [STS_W-1:0]  got_status;
    logic              got_free_valid;
    logic              m_open [NUM_CLASSES];  // model of each class's open zspage
    logic [WAY_W-1:0]  m_way [NUM_CLASSES];
    int                m_idx [NUM_CLASSES];

    tb_clk_gen u_clk_gen (.clk_i, .rst_ni);
    cmpresn_top u_cmpresn_top (.*);

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);  // one step per bit
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // smallest slot holding the page, NUM_CLASSES when kept uncompressed
    function automatic int size_class(input int size);
        if (size > 2048) return NUM_CLASSES;
        for (int c = 0; c < NUM_CLASSES; c++) begin
            if (size <= (512 << c)) return c;
        end
        return NUM_CLASSES;
    endfunction

    // memory responder and credit return, all driven on the falling edge
    always @(negedge clk_i) begin
        logic [LINE_W-1:0] data;
        int cost;
        mem_rsp_valid  = 1'b0;
        mem_rsp_err    = 1'b0;
        mem_credit_ret = 1'b0;
        wr_credit_ret  = 1'b0;
        if (rst_ni) begin
            if (total_req > total_rsp && take_bits(2) != 0) begin  // in order, random gaps
                cost = 1;                                          // mask byte
                for (int w = 0; w < 8; w++) begin
                    data[w*64 +: 64] = (int'(take_bits(5)) < zthresh) ? take_bits(64) : 64'd0;
                    if (data[w*64 +: 64] != 64'd0) cost += 8;
                end
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = data;
                mem_rsp_err   = err_page && (total_rsp % 64 == ERR_LINE);
                cum_cost += cost;
                total_rsp++;
            end
            if (total_rsp > mem_ret_drv && !hold_mem && take_bits(2) != 0) begin
                mem_credit_ret = 1'b1;
                mem_ret_drv++;
            end
            if (wr_sent > wr_ret_drv && !hold_wr && take_bits(1) != 0) begin
                wr_credit_ret = 1'b1;
                wr_ret_drv++;
            end
        end
    end

    // monitor samples on the rising edge, before outputs move
    always @(posedge clk_i) begin
        if (rst_ni) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout: DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Test FAILED");
                $fatal(1, "timeout");
            end
            if (mem_req_valid) begin
                check_eq(mem_req_addr, (ADDR_W'(cur_way) << 12) + ADDR_W'(64 * (total_req % 64)),
                         "read address");
                total_req++;
                check_eq(total_req <= 64 * pages, 1, "reads per trigger");
                check_eq(total_req - mem_seen_ret <= MEM_CREDITS, 1, "outstanding reads");
            end
            if (mem_credit_ret) mem_seen_ret++;
            if (wr_valid) begin
                wr_sent++;
                check_eq(wr_sent - wr_seen_ret <= WR_CREDITS, 1, "write without credit");
                got_wr_addr  = wr_addr;
                got_wr_size  = wr_size;
                got_wr_class = wr_class;
                got_wr_way   = wr_way;
            end
            if (wr_credit_ret) wr_seen_ret++;
            if (cmpresn_done) begin
                got_status     = done_status;
                got_cpage      = cpage_addr;
                got_free_valid = free_valid;
                got_free_way   = free_way;
                done_count++;
            end
        end
    end

    task automatic start_page(input logic [WAY_W-1:0] way, input int thr, input logic err);
        @(negedge clk_i);
        while (busy) @(negedge clk_i);
        cur_way   = way;       // responder is idle between pages
        zthresh   = thr;
        err_page  = err;
        cost_base = cum_cost;
        wr_base   = wr_sent;
        done_base = done_count;
        pages++;
        victim_way      = way;
        cmpresn_trigger = 1'b1;
        @(negedge clk_i);
        cmpresn_trigger = 1'b0;
    endtask

    task automatic finish_page(input logic [WAY_W-1:0] way);
        int size;
        int c;
        logic [ADDR_W-1:0] exp_addr;
        logic [STS_W-1:0] exp_sts;
        while (done_count == done_base) @(negedge clk_i);
        size = cum_cost - cost_base;
        c = size_class(size);
        check_eq(total_req, 64 * pages, "reads per page");
        if (c == NUM_CLASSES) begin
            check_eq(wr_sent, wr_base, "write for uncompressed page");
            check_eq(got_status, STS_UNCOMP, "status uncompressed");
            check_eq(got_cpage, ADDR_W'(way) << 12, "uncompressed page address");
            check_eq(got_free_valid, 0, "free on uncompressed page");
        end else begin
            exp_sts = m_open[c] ? STS_PACKED : STS_NEW_ZSPG;
            if (!m_open[c]) begin   // victim way hosts the new zspage
                m_open[c] = 1'b1;
                m_way[c]  = way;
                m_idx[c]  = 0;
            end
            exp_addr = (ADDR_W'(m_way[c]) << 12) + 64 + ADDR_W'(m_idx[c] * (512 << c));
            m_idx[c]++;
            if (m_idx[c] == 4032 / (512 << c)) m_open[c] = 1'b0;  // zspage full
            check_eq(wr_sent, wr_base + 1, "one write per page");
            check_eq(got_wr_addr, exp_addr, "write slot address");
            check_eq(got_wr_size, size, "write size");
            check_eq(got_wr_class, c, "write class");
            check_eq(got_wr_way, way, "write way");
            check_eq(got_status, exp_sts, "done status");
            check_eq(got_cpage, exp_addr, "compressed page address");
            check_eq(got_free_valid, exp_sts == STS_PACKED, "free valid");
            if (exp_sts == STS_PACKED) check_eq(got_free_way, way, "freed way");
        end
    endtask

    initial begin
        logic [WAY_W-1:0] way;
        lfsr_q = 32'ha9d1_f3e6;
        cmpresn_trigger = 1'b0;
        victim_way = '0;
        mem_credit_ret = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        mem_rsp_err = 1'b0;
        wr_credit_ret = 1'b0;
        cur_way = '0;
        {zthresh, err_page, hold_mem, hold_wr} = '0;
        {cycles, pages, total_req, total_rsp, mem_seen_ret, mem_ret_drv} = '0;
        {wr_sent, wr_seen_ret, wr_ret_drv, done_count, cum_cost} = '0;
        for (int c = 0; c < NUM_CLASSES; c++) begin
            m_open[c] = 1'b0;
            m_way[c]  = '0;
            m_idx[c]  = 0;
        end
        @(negedge clk_i);
        check_eq({busy, mem_req_valid, wr_valid, cmpresn_done, bus_error}, 0, "reset outputs");
        wait (rst_ni);

        for (int i = 0; i < 30; i++) begin   // random pages across all classes
            @(posedge clk_i);
            way = WAY_W'(take_bits(WAY_W));
            start_page(way, THRESH[int'(take_bits(3))], 1'b0);
            finish_page(way);
        end

        // use up write credits, then the next write has to wait
        @(posedge clk_i);
        hold_wr = 1'b1;
        while (wr_sent - wr_ret_drv < WR_CREDITS) begin
            @(posedge clk_i);
            way = WAY_W'(take_bits(WAY_W));
            start_page(way, 0, 1'b0);
            finish_page(way);
            @(posedge clk_i);
        end
        way = WAY_W'(take_bits(WAY_W));
        start_page(way, 1, 1'b0);
        @(posedge clk_i);
        while (total_rsp < 64 * pages) @(posedge clk_i);
        repeat (50) @(negedge clk_i);
        check_eq(wr_sent, wr_base, "write issued without credit");
        check_eq(done_count, done_base, "done before write credit");
        @(posedge clk_i);
        hold_wr = 1'b0;
        finish_page(way);

        // read credits withheld, only MEM_CREDITS reads go out
        @(posedge clk_i);
        while (total_rsp != mem_ret_drv) @(posedge clk_i);
        hold_mem = 1'b1;
        way = WAY_W'(take_bits(WAY_W));
        start_page(way, 6, 1'b0);
        while (total_req < 64 * (pages - 1) + MEM_CREDITS) @(negedge clk_i);
        repeat (30) @(negedge clk_i);
        check_eq(total_req, 64 * (pages - 1) + MEM_CREDITS, "reads without credit");
        @(posedge clk_i);
        hold_mem = 1'b0;
        finish_page(way);

        // error response, sticky and deaf to triggers
        @(posedge clk_i);
        way = WAY_W'(take_bits(WAY_W));
        start_page(way, 10, 1'b1);
        while (!bus_error) @(negedge clk_i);
        repeat (40) begin
            @(negedge clk_i);
            victim_way      = way + 1'b1;
            cmpresn_trigger = 1'b1;
            @(negedge clk_i);
            cmpresn_trigger = 1'b0;
            check_eq({busy, bus_error}, 2'b11, "bus error not held");
        end
        check_eq(done_count, done_base, "done after bus error");

        $display("Test OK");
        $finish;
    end

endmodule

/* src.f */
hw/cmpr_pkg.sv
hw/page_reader.sv
hw/line_compressor.sv
hw/size_class_bin.sv
hw/zspg_writer.sv
hw/cmpresn_mngr.sv
hw/cmpresn_top.sv
verif/tb_clk_gen.sv
verif/cmpresn_tb.sv
